//--- sources.f
source/conv_pkg.sv
source/kernel_pkg.sv
source/line_buffer.sv
source/window_gen.sv
source/kernel_mac.sv
source/conv_ctrl.sv
source/conv_top.sv
dv/conv_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the conv_tb simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module conv_tb -o conv_sim

out=$(./obj_dir/conv_sim)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

//--- dv/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    localparam int FRAME      = conv_pkg::FRAME_PIX;
    localparam int NUM_TESTS  = 7;
    localparam int FRAME_TMO  = 3000;  // cycles per frame including stalls.
    localparam int IDLE_TMO   = 100;

    localparam int PAT_RAMP   = 0;
    localparam int PAT_CONST  = 1;
    localparam int PAT_CHECK  = 2;
    localparam int PAT_RANDOM = 3;

    logic                       clk;
    logic                       rst;
    logic                       i_start;
    kernel_pkg::kernel_e        i_kernel;
    logic                       i_in_valid;
    logic [conv_pkg::PIX_W-1:0] i_in_pix;
    logic                       o_in_ready;
    logic                       o_out_valid;
    logic [conv_pkg::PIX_W-1:0] o_out_pix;
    logic                       o_out_last;
    logic                       i_out_ready;
    logic                       o_busy;

    // stimulus table with one frame per row.
    string               t_name   [NUM_TESTS];
    kernel_pkg::kernel_e t_kernel [NUM_TESTS];
    int                  t_pat    [NUM_TESTS];
    int                  t_gap    [NUM_TESTS];  // percent of cycles with no input.
    int                  t_stall  [NUM_TESTS];  // percent of cycles with no ready.

    int          img   [FRAME];
    int          exp_q [FRAME];
    int          total_errs;
    int          tests_failed;
    int          t;
    bit          timed_out;

    conv_top dut0 (
        .clk(clk), .rst(rst),
        .i_start(i_start), .i_kernel(i_kernel),
        .i_in_valid(i_in_valid), .i_in_pix(i_in_pix), .o_in_ready(o_in_ready),
        .o_out_valid(o_out_valid), .o_out_pix(o_out_pix), .o_out_last(o_out_last),
        .i_out_ready(i_out_ready), .o_busy(o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_test(input int idx, input string name, input kernel_pkg::kernel_e k,
                            input int pat, input int gap, input int stall);
        t_name[idx]   = name;
        t_kernel[idx] = k;
        t_pat[idx]    = pat;
        t_gap[idx]    = gap;
        t_stall[idx]  = stall;
    endtask

    task automatic load_table();
        add_test(0, "identity_ramp",   kernel_pkg::K_IDENTITY, PAT_RAMP,   0,  0);
        add_test(1, "box_const",       kernel_pkg::K_BOX,      PAT_CONST,  0,  0);
        add_test(2, "sharpen_checker", kernel_pkg::K_SHARPEN,  PAT_CHECK,  0,  0);
        add_test(3, "edge_checker",    kernel_pkg::K_EDGE,     PAT_CHECK,  20, 20);
        add_test(4, "sharpen_random",  kernel_pkg::K_SHARPEN,  PAT_RANDOM, 30, 40);
        add_test(5, "box_random",      kernel_pkg::K_BOX,      PAT_RANDOM, 25, 25);
        add_test(6, "edge_random",     kernel_pkg::K_EDGE,     PAT_RANDOM, 10, 50);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // reference filter
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic int pix_at(input int r, input int c);
        if (r < 0 || r >= conv_pkg::IMG_ROWS || c < 0 || c >= conv_pkg::IMG_COLS) begin
            return 0;  // zero padding.
        end
        return img[r * conv_pkg::IMG_COLS + c];
    endfunction

    function automatic int ref_pix(input int r, input int c, input kernel_pkg::kernel_e k);
        int ctr;
        int edg;
        int cor;
        int sum;
        ctr = pix_at(r, c);
        edg = pix_at(r - 1, c) + pix_at(r, c - 1) + pix_at(r, c + 1) + pix_at(r + 1, c);
        cor = pix_at(r - 1, c - 1) + pix_at(r - 1, c + 1)
            + pix_at(r + 1, c - 1) + pix_at(r + 1, c + 1);
        case (k)
            kernel_pkg::K_IDENTITY: sum = ctr;
            kernel_pkg::K_BOX:      sum = (ctr + edg + cor) / 8;
            kernel_pkg::K_SHARPEN:  sum = 5 * ctr - edg;
            default:                sum = 8 * ctr - edg - cor;
        endcase
        if (sum < 0) begin
            sum = 0;
        end else if (sum > 255) begin
            sum = 255;
        end
        return sum;
    endfunction

    task automatic fill_image(input int pat, input kernel_pkg::kernel_e k);
        for (int i = 0; i < FRAME; i++) begin
            case (pat)
                PAT_RAMP:  img[i] = (i * 5 + 3) % 256;
                PAT_CONST: img[i] = 200;
                PAT_CHECK: img[i] = (((i / conv_pkg::IMG_COLS) + (i % conv_pkg::IMG_COLS)) % 2)
                                    ? 255 : 0;
                default:   img[i] = int'($urandom % 256);
            endcase
        end
        for (int i = 0; i < FRAME; i++) begin
            exp_q[i] = ref_pix(i / conv_pkg::IMG_COLS, i % conv_pkg::IMG_COLS, k);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // frame driver
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (o_busy && cycles < IDLE_TMO) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (o_busy) begin
            $display("timeout: DUT still busy before the start of test %0d", t);
            total_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_frame(input int idx);
        int in_idx;
        int in_acc;
        int out_cnt;
        int cycles;
        int errs;
        bit pending;
        bit exp_last;
        in_idx  = 0;
        in_acc  = 0;
        out_cnt = 0;
        cycles  = 0;
        errs    = 0;
        pending = 1'b0;
        fill_image(t_pat[idx], t_kernel[idx]);
        @(posedge clk);
        #2;
        assert (!o_in_ready) else begin
            $display("%s: input ready high while idle", t_name[idx]);
            errs++;
        end
        i_start  = 1'b1;
        i_kernel = t_kernel[idx];
        @(posedge clk);
        #2;
        i_start  = 1'b0;
        i_kernel = kernel_pkg::K_IDENTITY;  // later changes must not reach this frame.
        assert (o_busy) else begin
            $display("%s: busy did not rise after the start pulse", t_name[idx]);
            errs++;
        end
        while (out_cnt < FRAME && cycles < FRAME_TMO) begin
            if (in_idx < FRAME) begin
                if (!pending) begin
                    i_in_valid = int'($urandom % 100) >= t_gap[idx];
                end
                i_in_pix = 8'(img[in_idx]);
            end else begin
                i_in_valid = 1'b1;  // extra beats that must be refused outside the run state.
                i_in_pix   = 8'hff;
            end
            i_out_ready = int'($urandom % 100) >= t_stall[idx];
            @(negedge clk);
            if (i_in_valid && o_in_ready) begin
                in_acc++;
                if (in_idx < FRAME) in_idx++;
                pending = 1'b0;
            end else begin
                pending = i_in_valid;
            end
            if (o_out_valid && i_out_ready) begin
                exp_last = (out_cnt == FRAME - 1);
                assert (o_out_pix == 8'(exp_q[out_cnt])) else begin
                    $display("ERROR %s pixel %0d: expected %0d, actual %0d",
                             t_name[idx], out_cnt, exp_q[out_cnt], o_out_pix);
                    errs++;
                end
                assert (o_out_last == exp_last) else begin
                    $display("ERROR %s last flag at pixel %0d: expected %0d, actual %0d",
                             t_name[idx], out_cnt, exp_last, o_out_last);
                    errs++;
                end
                out_cnt++;
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        if (out_cnt < FRAME) begin
            $display("timeout: %s produced only %0d of %0d outputs", t_name[idx], out_cnt, FRAME);
            errs++;
            timed_out = 1'b1;
        end else begin
            assert (!o_busy) else begin
                $display("%s: busy still high after the last output", t_name[idx]);
                errs++;
            end
            assert (!o_out_valid) else begin
                $display("%s: an output was offered after the last one", t_name[idx]);
                errs++;
            end
            assert (in_acc == FRAME) else begin
                $display("ERROR %s accepted inputs: expected %0d, actual %0d",
                         t_name[idx], FRAME, in_acc);
                errs++;
            end
        end
        i_in_valid  = 1'b0;
        i_out_ready = 1'b0;
        $display("test %0d %s: %0d outputs, %0d errors, %s", idx, t_name[idx], out_cnt, errs,
                 (errs == 0) ? "pass" : "fail");
        total_errs += errs;
        if (errs != 0) tests_failed++;
    endtask

    initial begin
        void'($urandom(40));
        rst          = 1'b1;
        i_start      = 1'b0;
        i_kernel     = kernel_pkg::K_IDENTITY;
        i_in_valid   = 1'b0;
        i_in_pix     = '0;
        i_out_ready  = 1'b0;
        total_errs   = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // frames run back to back with their own kernels.
        for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
            wait_idle();
            if (!timed_out) run_frame(t);
        end
        $display("tests run %0d, failed %0d, errors %0d", t, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_start,
    input  wire  kernel_pkg::kernel_e    i_kernel,
    input  wire                          i_in_valid,
    input  wire  [conv_pkg::PIX_W-1:0]   i_in_pix,
    output logic                         o_in_ready,
    output logic                         o_out_valid,
    output logic [conv_pkg::PIX_W-1:0]   o_out_pix,
    output logic                         o_out_last,
    input  wire                          i_out_ready,
    output logic                         o_busy
);

    logic                       adv;
    logic                       shift;
    logic                       win_step;
    logic                       last_done;
    logic [conv_pkg::PIX_W-1:0] shift_pix;
    logic [conv_pkg::PIX_W-1:0] row0, row1, row2;
    logic [conv_pkg::PIX_W-1:0] w0, w1, w2, w3, w4, w5, w6, w7, w8;
    logic                       win_valid, win_last;
    kernel_pkg::kernel_e        kernel;

    assign last_done = o_out_valid && i_out_ready && o_out_last;

    conv_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .i_start(i_start), .i_kernel(i_kernel),
        .i_in_valid(i_in_valid), .i_in_pix(i_in_pix),
        .i_adv(adv), .i_out_last_done(last_done),
        .o_in_ready(o_in_ready), .o_shift(shift), .o_shift_pix(shift_pix),
        .o_win_step(win_step), .o_kernel(kernel), .o_busy(o_busy)
    );

    line_buffer u_lbuf (
        .clk(clk), .rst(rst),
        .i_shift(shift), .i_pix(shift_pix),
        .o_row0(row0), .o_row1(row1), .o_row2(row2)
    );

    window_gen u_win (
        .clk(clk), .rst(rst),
        .i_shift(shift), .i_step(win_step), .i_adv(adv),
        .i_row0(row0), .i_row1(row1), .i_row2(row2),
        .o_w0(w0), .o_w1(w1), .o_w2(w2), .o_w3(w3), .o_w4(w4),
        .o_w5(w5), .o_w6(w6), .o_w7(w7), .o_w8(w8),
        .o_win_valid(win_valid), .o_win_last(win_last)
    );

    kernel_mac u_mac (
        .clk(clk), .rst(rst),
        .i_kernel(kernel), .i_win_valid(win_valid),
        .i_w0(w0), .i_w1(w1), .i_w2(w2), .i_w3(w3), .i_w4(w4),
        .i_w5(w5), .i_w6(w6), .i_w7(w7), .i_w8(w8),
        .i_out_ready(i_out_ready), .i_last(win_last),
        .o_adv(adv), .o_out_valid(o_out_valid),
        .o_out_pix(o_out_pix), .o_out_last(o_out_last)
    );

endmodule

`default_nettype wire

//--- source/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_start,
    input  wire  kernel_pkg::kernel_e    i_kernel,
    input  wire                          i_in_valid,
    input  wire  [conv_pkg::PIX_W-1:0]   i_in_pix,
    input  wire                          i_adv,
    input  wire                          i_out_last_done,
    output logic                         o_in_ready,
    output logic                         o_shift,
    output logic [conv_pkg::PIX_W-1:0]   o_shift_pix,
    output logic                         o_win_step,
    output kernel_pkg::kernel_e          o_kernel,
    output logic                         o_busy
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FLUSH,
        DRAIN
    } state_e;

    state_e                      state;
    logic [conv_pkg::BEAT_W-1:0] beat;   // input and flush beats of this frame.
    logic                        last_in, last_flush;

    assign last_in    = (beat == conv_pkg::BEAT_W'(conv_pkg::FRAME_PIX - 1));
    assign last_flush = (beat == conv_pkg::BEAT_W'(conv_pkg::TOTAL_BEATS - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // strobes
    // ~~~~~~~~~~~~~~~~~~~~
    assign o_in_ready  = (state == RUN) && i_adv;
    assign o_shift     = (o_in_ready && i_in_valid) || ((state == FLUSH) && i_adv);
    assign o_shift_pix = (state == FLUSH) ? '0 : i_in_pix; // zero flush beats.
    assign o_win_step  = o_shift && (beat >= conv_pkg::BEAT_W'(conv_pkg::PRIME_BEATS));
    assign o_busy      = (state != IDLE);

    // ~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    beat <= '0;
                    if (i_start) state <= RUN;
                end
                RUN: begin
                    if (o_shift) begin
                        beat <= beat + 1'b1;
                        if (last_in) state <= FLUSH;
                    end
                end
                FLUSH: begin
                    if (o_shift) begin
                        beat <= beat + 1'b1;
                        if (last_flush) state <= DRAIN;
                    end
                end
                default: begin
                    if (i_out_last_done) state <= IDLE; // last pixel taken.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_kernel <= kernel_pkg::K_IDENTITY;
        end else if ((state == IDLE) && i_start) begin
            o_kernel <= i_kernel;  // held for the whole frame.
        end
    end

endmodule

`default_nettype wire

//--- source/kernel_mac.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_mac (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  kernel_pkg::kernel_e    i_kernel,
    input  wire                          i_win_valid,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w0,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w1,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w2,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w3,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w4,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w5,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w6,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w7,
    input  wire  [conv_pkg::PIX_W-1:0]   i_w8,
    input  wire                          i_out_ready,
    input  wire                          i_last,
    output logic                         o_adv,
    output logic                         o_out_valid,
    output logic [conv_pkg::PIX_W-1:0]   o_out_pix,
    output logic                         o_out_last
);

    logic                             s1_valid;
    logic                             s1_last;
    logic [conv_pkg::PIX_W-1:0]       s1_center;
    logic [kernel_pkg::SUM_W-1:0]     s1_edge;    // up, left, right, down.
    logic [kernel_pkg::SUM_W-1:0]     s1_corner;

    logic signed [kernel_pkg::ACC_W-1:0] c_s, e_s, k_s;
    logic signed [kernel_pkg::ACC_W-1:0] acc;
    logic [conv_pkg::PIX_W-1:0]          sat_pix;

    // the whole pipeline stalls while a result waits for the consumer.
    assign o_adv = !o_out_valid || i_out_ready;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage one
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (o_adv) begin
            s1_center <= i_w4;
            s1_edge   <= kernel_pkg::SUM_W'(i_w1) + kernel_pkg::SUM_W'(i_w3)
                       + kernel_pkg::SUM_W'(i_w5) + kernel_pkg::SUM_W'(i_w7);
            s1_corner <= kernel_pkg::SUM_W'(i_w0) + kernel_pkg::SUM_W'(i_w2)
                       + kernel_pkg::SUM_W'(i_w6) + kernel_pkg::SUM_W'(i_w8);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stage two
    // ~~~~~~~~~~~~~~~~~~~~
    assign c_s = kernel_pkg::ACC_W'(s1_center);
    assign e_s = kernel_pkg::ACC_W'(s1_edge);
    assign k_s = kernel_pkg::ACC_W'(s1_corner);

    always_comb begin
        case (i_kernel)
            kernel_pkg::K_IDENTITY: acc = c_s;
            kernel_pkg::K_BOX:      acc = (c_s + e_s + k_s) >>> kernel_pkg::BOX_SHIFT;
            kernel_pkg::K_SHARPEN:  acc = (c_s <<< 2) + c_s - e_s;
            default:                acc = (c_s <<< 3) - e_s - k_s; // edge detect.
        endcase
    end

    // clamp to 0..255.
    always_comb begin
        if (acc[kernel_pkg::ACC_W-1]) begin
            sat_pix = '0;
        end else if (|acc[kernel_pkg::ACC_W-2:conv_pkg::PIX_W]) begin
            sat_pix = '1;
        end else begin
            sat_pix = acc[conv_pkg::PIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (o_adv) begin
            o_out_pix <= sat_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            s1_last     <= 1'b0;
            o_out_valid <= 1'b0;
            o_out_last  <= 1'b0;
        end else if (o_adv) begin
            s1_valid    <= i_win_valid;
            s1_last     <= i_win_valid && i_last;
            o_out_valid <= s1_valid;
            o_out_last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

//--- source/window_gen.sv
`timescale 1ns/1ps
`default_nettype none

module window_gen (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_shift,
    input  wire                          i_step,
    input  wire                          i_adv,
    input  wire  [conv_pkg::PIX_W-1:0]   i_row0,
    input  wire  [conv_pkg::PIX_W-1:0]   i_row1,
    input  wire  [conv_pkg::PIX_W-1:0]   i_row2,
    output logic [conv_pkg::PIX_W-1:0]   o_w0,
    output logic [conv_pkg::PIX_W-1:0]   o_w1,
    output logic [conv_pkg::PIX_W-1:0]   o_w2,
    output logic [conv_pkg::PIX_W-1:0]   o_w3,
    output logic [conv_pkg::PIX_W-1:0]   o_w4,
    output logic [conv_pkg::PIX_W-1:0]   o_w5,
    output logic [conv_pkg::PIX_W-1:0]   o_w6,
    output logic [conv_pkg::PIX_W-1:0]   o_w7,
    output logic [conv_pkg::PIX_W-1:0]   o_w8,
    output logic                         o_win_valid,
    output logic                         o_win_last
);

    // column 0 is the left edge and column 2 takes the new taps.
    logic [conv_pkg::PIX_W-1:0] top_sr [3];
    logic [conv_pkg::PIX_W-1:0] mid_sr [3];
    logic [conv_pkg::PIX_W-1:0] bot_sr [3];

    logic                       step_q;  // shift registers hold a full window.
    logic                       load;
    logic [conv_pkg::ROW_W-1:0] cen_row;
    logic [conv_pkg::COL_W-1:0] cen_col;
    logic                       row_first, row_last;
    logic                       col_first, col_last;

    assign load      = i_adv && step_q;
    assign row_first = (cen_row == '0);
    assign row_last  = (cen_row == conv_pkg::ROW_W'(conv_pkg::IMG_ROWS - 1));
    assign col_first = (cen_col == '0);
    assign col_last  = (cen_col == conv_pkg::COL_W'(conv_pkg::IMG_COLS - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // neighborhood shift
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (i_shift) begin
            top_sr[0] <= top_sr[1];
            top_sr[1] <= top_sr[2];
            top_sr[2] <= i_row2;   // oldest row on top.
            mid_sr[0] <= mid_sr[1];
            mid_sr[1] <= mid_sr[2];
            mid_sr[2] <= i_row1;
            bot_sr[0] <= bot_sr[1];
            bot_sr[1] <= bot_sr[2];
            bot_sr[2] <= i_row0;   // newest row at the bottom.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // position and flags
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            step_q      <= 1'b0;
            o_win_valid <= 1'b0;
            o_win_last  <= 1'b0;
            cen_row     <= '0;
            cen_col     <= '0;
        end else if (i_adv) begin
            step_q      <= i_step;
            o_win_valid <= step_q;
            if (step_q) begin
                o_win_last <= row_last && col_last;
                if (col_last) begin
                    cen_col <= '0;
                    cen_row <= row_last ? '0 : cen_row + 1'b1;
                end else begin
                    cen_col <= cen_col + 1'b1;
                end
            end
        end
    end

    // zero padding outside the frame.
    always_ff @(posedge clk) begin
        if (load) begin
            o_w0 <= (row_first || col_first) ? '0 : top_sr[0];
            o_w1 <= row_first                ? '0 : top_sr[1];
            o_w2 <= (row_first || col_last)  ? '0 : top_sr[2];
            o_w3 <= col_first                ? '0 : mid_sr[0];
            o_w4 <= mid_sr[1];
            o_w5 <= col_last                 ? '0 : mid_sr[2];
            o_w6 <= (row_last || col_first)  ? '0 : bot_sr[0];
            o_w7 <= row_last                 ? '0 : bot_sr[1];
            o_w8 <= (row_last || col_last)   ? '0 : bot_sr[2];
        end
    end

endmodule

`default_nettype wire

//--- source/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          i_shift,
    input  wire  [conv_pkg::PIX_W-1:0]   i_pix,
    output logic [conv_pkg::PIX_W-1:0]   o_row0,
    output logic [conv_pkg::PIX_W-1:0]   o_row1,
    output logic [conv_pkg::PIX_W-1:0]   o_row2
);

    logic [conv_pkg::PIX_W-1:0] mem0 [conv_pkg::IMG_COLS]; // one row back.
    logic [conv_pkg::PIX_W-1:0] mem1 [conv_pkg::IMG_COLS]; // two rows back.

    logic [conv_pkg::COL_W-1:0] col_ptr;
    logic                       ptr_wrap;

    assign ptr_wrap = (col_ptr == conv_pkg::COL_W'(conv_pkg::IMG_COLS - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // row taps
    // ~~~~~~~~~~~~~~~~~~~~

    // the slot under the pointer holds the pixel one row (mem0) and
    // two rows (mem1) above the incoming one.
    assign o_row0 = i_pix;
    assign o_row1 = mem0[col_ptr];
    assign o_row2 = mem1[col_ptr];

    // ~~~~~~~~~~~~~~~~~~~~
    // cascade write back
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (i_shift) begin
            mem0[col_ptr] <= i_pix;
            mem1[col_ptr] <= mem0[col_ptr]; // row1 moves down to row2.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_ptr <= '0;
        end else if (i_shift) begin
            if (ptr_wrap) begin
                col_ptr <= '0;
            end else begin
                col_ptr <= col_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/kernel_pkg.sv
`default_nettype none

package kernel_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // kernel opcodes
    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        K_IDENTITY = 2'd0,  // center pixel.
        K_BOX      = 2'd1,  // sum of nine divided by eight.
        K_SHARPEN  = 2'd2,  // 5*center minus the four edge taps.
        K_EDGE     = 2'd3   // 8*center minus the other eight.
    } kernel_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // arithmetic widths
    // ~~~~~~~~~~~~~~~~~~~~

    // sum of four pixels.
    localparam int SUM_W = conv_pkg::PIX_W + 2;

    // signed accumulator covering -2040..+2295.
    localparam int ACC_W = 13;

    // box filter divides by eight.
    localparam int BOX_SHIFT = 3;

endpackage

`default_nettype wire

//--- source/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // frame geometry
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int IMG_ROWS = 6;
    localparam int IMG_COLS = 8;
    localparam int PIX_W    = 8;

    localparam int FRAME_PIX = IMG_ROWS * IMG_COLS;

    // one row plus one pixel before the first window is complete.
    localparam int PRIME_BEATS = IMG_COLS + 1;
    localparam int TOTAL_BEATS = FRAME_PIX + PRIME_BEATS; // input plus flush.

    // ~~~~~~~~~~~~~~~~~~~~
    // counter widths
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int ROW_W  = $clog2(IMG_ROWS);
    localparam int COL_W  = $clog2(IMG_COLS);
    localparam int BEAT_W = $clog2(TOTAL_BEATS + 1);

endpackage

`default_nettype wire
